// File: hdl/rx_pkg.sv
package rx_pkg;

    // ----------------------------------------
    // datapath widths
    // ----------------------------------------
    localparam int IQ_W     = 16;
    // Q in the upper half, I in the lower half
    localparam int SAMPLE_W = 2 * IQ_W;
    localparam int LLR_W    = 8;
    localparam int PHASE_W  = 20;

    // ----------------------------------------
    // register bus
    // ----------------------------------------
    localparam int BUS_ADDR_W = 8;
    localparam int OFFSET_W   = 6;
    localparam int BUS_DATA_W = 32;

    // top two address bits
    typedef enum logic [1:0] {
        REGION_FIFO  = 2'd0,
        REGION_CTRL  = 2'd1,
        REGION_RSVD2 = 2'd2,
        REGION_RSVD3 = 2'd3
    } region_t;

    typedef enum logic [OFFSET_W-1:0] {
        CTRL_ENABLE = 6'd0,
        CTRL_CFO    = 6'd1
    } ctrl_reg_t;

    typedef enum logic [OFFSET_W-1:0] {
        FIFO_DATA  = 6'd0,
        FIFO_LEVEL = 6'd1
    } fifo_reg_t;

    // symbol kind carried alongside each sample
    typedef enum logic [1:0] {
        KIND_OTHER = 2'd0,
        KIND_PSS   = 2'd1,
        KIND_SSS   = 2'd2,
        KIND_PBCH  = 2'd3
    } sym_kind_t;

endpackage

// File: hdl/cfo_derotator.sv
`timescale 1ns/1ps

module cfo_derotator
    import rx_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic                enable_i,
    input  logic                cfo_valid_i,
    input  logic [PHASE_W-1:0]  cfo_inc_i,
    input  logic [SAMPLE_W-1:0] sample_i,
    input  sym_kind_t           sample_kind_i,
    input  logic                sample_valid_i,
    output logic [SAMPLE_W-1:0] rot_o,
    output sym_kind_t           rot_kind_o,
    output logic                rot_valid_o,
    output logic [PHASE_W-1:0]  freq_o
);

    localparam logic signed [IQ_W-1:0] IQ_MIN = {1'b1, {(IQ_W-1){1'b0}}};
    localparam logic signed [IQ_W-1:0] IQ_MAX = {1'b0, {(IQ_W-1){1'b1}}};

    logic [PHASE_W-1:0]     freq;
    logic [PHASE_W-1:0]     phase;
    logic                   accept;
    logic [1:0]             quadrant;
    logic signed [IQ_W-1:0] in_i, in_q;
    logic signed [IQ_W-1:0] out_i, out_q;

    // negation that cannot wrap
    function automatic logic signed [IQ_W-1:0] neg_sat(input logic signed [IQ_W-1:0] x);
        return (x == IQ_MIN) ? IQ_MAX : -x;
    endfunction

    assign accept   = sample_valid_i && enable_i;
    assign quadrant = phase[PHASE_W-1 -: 2];
    assign in_i     = sample_i[IQ_W-1:0];
    assign in_q     = sample_i[SAMPLE_W-1 -: IQ_W];
    assign freq_o   = freq;

    // quarter turns only
    always_comb begin
        case (quadrant)
            2'd0: begin out_i = in_i;          out_q = in_q;          end
            2'd1: begin out_i = neg_sat(in_q); out_q = in_i;          end
            2'd2: begin out_i = neg_sat(in_i); out_q = neg_sat(in_q); end
            default: begin out_i = in_q;       out_q = neg_sat(in_i); end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            freq        <= '0;
            phase       <= '0;
            rot_valid_o <= 1'b0;
        end else begin
            // corrections are relative to the current frequency
            if (cfo_valid_i)
                freq <= freq - cfo_inc_i;
            if (accept)
                phase <= phase + freq;
            rot_valid_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rot_o      <= {out_q, out_i};
            rot_kind_o <= sample_kind_i;
        end
    end

endmodule

// File: hdl/llr_demapper.sv
`timescale 1ns/1ps

module llr_demapper
    import rx_pkg::*;
#(
    parameter int LLR_SHIFT = 8
)(
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic [SAMPLE_W-1:0] rot_i,
    input  sym_kind_t           rot_kind_i,
    input  logic                rot_valid_i,
    output logic [LLR_W-1:0]    llr_o,
    output sym_kind_t           llr_kind_o,
    output logic                llr_last_o,
    output logic                llr_valid_o
);

    localparam logic signed [IQ_W-1:0] POS_LIM = IQ_W'(2 ** (LLR_W - 1) - 1);
    localparam logic signed [IQ_W-1:0] NEG_LIM = -POS_LIM;

    logic [LLR_W-1:0] q_hold;
    logic             q_pending;

    // shift then clip symmetrically
    function automatic logic [LLR_W-1:0] to_llr(input logic signed [IQ_W-1:0] x);
        logic signed [IQ_W-1:0] s;
        s = x >>> LLR_SHIFT;
        if (s > POS_LIM)
            return POS_LIM[LLR_W-1:0];
        else if (s < NEG_LIM)
            return NEG_LIM[LLR_W-1:0];
        return s[LLR_W-1:0];
    endfunction

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            llr_valid_o <= 1'b0;
            llr_last_o  <= 1'b0;
            q_pending   <= 1'b0;
        end else begin
            llr_valid_o <= rot_valid_i || q_pending;
            llr_last_o  <= q_pending;
            q_pending   <= rot_valid_i;
        end
    end

    // I first, Q one cycle later with the same tag
    always_ff @(posedge clk_i) begin
        if (rot_valid_i) begin
            llr_o      <= to_llr(rot_i[IQ_W-1:0]);
            q_hold     <= to_llr(rot_i[SAMPLE_W-1 -: IQ_W]);
            llr_kind_o <= rot_kind_i;
        end else if (q_pending) begin
            llr_o <= q_hold;
        end
    end

endmodule

// File: hdl/pbch_llr_fifo.sv
`timescale 1ns/1ps

module pbch_llr_fifo
    import rx_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
)(
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  logic [LLR_W-1:0]      llr_i,
    input  sym_kind_t             llr_kind_i,
    input  logic                  llr_valid_i,
    input  logic                  sel_i,
    input  logic                  we_i,
    input  logic [OFFSET_W-1:0]   offset_i,
    output logic [BUS_DATA_W-1:0] rdata_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [LLR_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             overflow;
    logic             push_req, push, pop, full, empty;
    fifo_reg_t        reg_sel;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign reg_sel  = fifo_reg_t'(offset_i);
    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    // only PBCH LLRs are kept
    assign push_req = llr_valid_i && (llr_kind_i == KIND_PBCH);
    assign push     = push_req && !full;
    assign pop      = sel_i && !we_i && (reg_sel == FIFO_DATA) && !empty;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
            if (sel_i && we_i && (reg_sel == FIFO_LEVEL))
                overflow <= 1'b0;
            if (push_req && full)
                overflow <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push)
            mem[wr_ptr] <= llr_i;
    end

    always_comb begin
        rdata_o = '0;
        case (reg_sel)
            FIFO_DATA: if (!empty)
                rdata_o = {{(BUS_DATA_W-LLR_W){mem[rd_ptr][LLR_W-1]}}, mem[rd_ptr]};
            FIFO_LEVEL: begin
                rdata_o[CNT_W-1:0]      = count;
                rdata_o[BUS_DATA_W-1]   = overflow;
            end
            default: rdata_o = '0;
        endcase
    end

endmodule

// File: hdl/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs
    import rx_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      sel_i,
    input  logic                      we_i,
    input  logic [OFFSET_W-1:0]       offset_i,
    input  logic [BUS_DATA_W-1:0]     wdata_i,
    output logic [BUS_DATA_W-1:0]     rdata_o,
    input  logic signed [PHASE_W-1:0] freq_i,
    output logic                      enable_o,
    output logic                      cfo_valid_o,
    output logic signed [PHASE_W-1:0] cfo_inc_o
);

    ctrl_reg_t reg_sel;
    logic      wr_enable;
    logic      wr_cfo;

    assign reg_sel   = ctrl_reg_t'(offset_i);
    assign wr_enable = sel_i && we_i && (reg_sel == CTRL_ENABLE);
    assign wr_cfo    = sel_i && we_i && (reg_sel == CTRL_CFO);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            enable_o    <= 1'b0;
            cfo_valid_o <= 1'b0;
        end else begin
            cfo_valid_o <= wr_cfo;
            if (wr_enable)
                enable_o <= wdata_i[0];
        end
    end

    // low bits of the write, signed
    always_ff @(posedge clk_i) begin
        if (wr_cfo)
            cfo_inc_o <= wdata_i[PHASE_W-1:0];
    end

    always_comb begin
        case (reg_sel)
            CTRL_ENABLE: rdata_o = {{(BUS_DATA_W-1){1'b0}}, enable_o};
            CTRL_CFO:    rdata_o = {{(BUS_DATA_W-PHASE_W){freq_i[PHASE_W-1]}}, freq_i};
            default:     rdata_o = '0;
        endcase
    end

endmodule

// File: hdl/reg_bus_decoder.sv
`timescale 1ns/1ps

module reg_bus_decoder
    import rx_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  logic                  bus_req_i,
    input  logic                  bus_we_i,
    input  logic [BUS_ADDR_W-1:0] bus_addr_i,
    input  logic [BUS_DATA_W-1:0] bus_wdata_i,
    output logic [BUS_DATA_W-1:0] bus_rdata_o,
    output logic                  bus_ack_o,
    output logic                  bus_err_o,
    output logic                  ctrl_sel_o,
    output logic                  fifo_sel_o,
    output logic                  we_o,
    output logic [OFFSET_W-1:0]   offset_o,
    output logic [BUS_DATA_W-1:0] wdata_o,
    input  logic [BUS_DATA_W-1:0] ctrl_rdata_i,
    input  logic [BUS_DATA_W-1:0] fifo_rdata_i
);

    region_t region;
    logic    mapped;

    assign region     = region_t'(bus_addr_i[BUS_ADDR_W-1 -: 2]);
    assign ctrl_sel_o = bus_req_i && (region == REGION_CTRL);
    assign fifo_sel_o = bus_req_i && (region == REGION_FIFO);
    assign mapped     = (region == REGION_CTRL) || (region == REGION_FIFO);
    assign we_o       = bus_we_i;
    assign offset_o   = bus_addr_i[OFFSET_W-1:0];
    assign wdata_o    = bus_wdata_i;

    // fixed one-cycle response
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bus_ack_o <= 1'b0;
            bus_err_o <= 1'b0;
        end else begin
            bus_ack_o <= bus_req_i;
            bus_err_o <= bus_req_i && !mapped;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_req_i) begin
            case (region)
                REGION_FIFO: bus_rdata_o <= fifo_rdata_i;
                REGION_CTRL: bus_rdata_o <= ctrl_rdata_i;
                default:     bus_rdata_o <= '0;
            endcase
        end
    end

endmodule

// File: hdl/rx_top.sv
`timescale 1ns/1ps

module rx_top
    import rx_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int LLR_SHIFT  = 8
)(
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  logic [SAMPLE_W-1:0]   sample_i,
    input  sym_kind_t             sample_kind_i,
    input  logic                  sample_valid_i,

    output logic [LLR_W-1:0]      llr_o,
    output sym_kind_t             llr_kind_o,
    output logic                  llr_last_o,
    output logic                  llr_valid_o,

    input  logic                  bus_req_i,
    input  logic                  bus_we_i,
    input  logic [BUS_ADDR_W-1:0] bus_addr_i,
    input  logic [BUS_DATA_W-1:0] bus_wdata_i,
    output logic [BUS_DATA_W-1:0] bus_rdata_o,
    output logic                  bus_ack_o,
    output logic                  bus_err_o
);

    // ----------------------------------------
    // register side
    // ----------------------------------------
    logic                       ctrl_sel;
    logic                       fifo_sel;
    logic                       reg_we;
    logic [OFFSET_W-1:0]        reg_offset;
    logic [BUS_DATA_W-1:0]      reg_wdata;
    logic [BUS_DATA_W-1:0]      ctrl_rdata;
    logic [BUS_DATA_W-1:0]      fifo_rdata;

    logic                       rx_enable;
    logic                       cfo_valid;
    logic signed [PHASE_W-1:0]  cfo_inc;
    logic signed [PHASE_W-1:0]  freq;

    // ----------------------------------------
    // sample path
    // ----------------------------------------
    logic [SAMPLE_W-1:0]        rot;
    sym_kind_t                  rot_kind;
    logic                       rot_valid;

    reg_bus_decoder reg_bus_decoder_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .bus_req_i    (bus_req_i),
        .bus_we_i     (bus_we_i),
        .bus_addr_i   (bus_addr_i),
        .bus_wdata_i  (bus_wdata_i),
        .bus_rdata_o  (bus_rdata_o),
        .bus_ack_o    (bus_ack_o),
        .bus_err_o    (bus_err_o),
        .ctrl_sel_o   (ctrl_sel),
        .fifo_sel_o   (fifo_sel),
        .we_o         (reg_we),
        .offset_o     (reg_offset),
        .wdata_o      (reg_wdata),
        .ctrl_rdata_i (ctrl_rdata),
        .fifo_rdata_i (fifo_rdata)
    );

    ctrl_regs ctrl_regs_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .sel_i       (ctrl_sel),
        .we_i        (reg_we),
        .offset_i    (reg_offset),
        .wdata_i     (reg_wdata),
        .rdata_o     (ctrl_rdata),
        .freq_i      (freq),
        .enable_o    (rx_enable),
        .cfo_valid_o (cfo_valid),
        .cfo_inc_o   (cfo_inc)
    );

    cfo_derotator cfo_derotator_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .enable_i       (rx_enable),
        .cfo_valid_i    (cfo_valid),
        .cfo_inc_i      (cfo_inc),
        .sample_i       (sample_i),
        .sample_kind_i  (sample_kind_i),
        .sample_valid_i (sample_valid_i),
        .rot_o          (rot),
        .rot_kind_o     (rot_kind),
        .rot_valid_o    (rot_valid),
        .freq_o         (freq)
    );

    llr_demapper #(.LLR_SHIFT(LLR_SHIFT)) llr_demapper_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .rot_i       (rot),
        .rot_kind_i  (rot_kind),
        .rot_valid_i (rot_valid),
        .llr_o       (llr_o),
        .llr_kind_o  (llr_kind_o),
        .llr_last_o  (llr_last_o),
        .llr_valid_o (llr_valid_o)
    );

    pbch_llr_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) pbch_llr_fifo_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .llr_i       (llr_o),
        .llr_kind_i  (llr_kind_o),
        .llr_valid_i (llr_valid_o),
        .sel_i       (fifo_sel),
        .we_i        (reg_we),
        .offset_i    (reg_offset),
        .rdata_o     (fifo_rdata)
    );

endmodule

// File: include/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// include after clk and the bus_* signals of the testbench are declared

// galois lfsr, one step per bit taken from bit 0
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic logic signed [IQ_W-1:0] neg_sat_ref(input logic signed [IQ_W-1:0] x);
    return (x == {1'b1, {(IQ_W-1){1'b0}}}) ? {1'b0, {(IQ_W-1){1'b1}}} : -x;
endfunction

// expected derotator output for quadrant q
function automatic logic [SAMPLE_W-1:0] rotate_ref(input logic [SAMPLE_W-1:0] s,
                                                   input logic [1:0] q);
    logic signed [IQ_W-1:0] i;
    logic signed [IQ_W-1:0] qq;
    i  = s[IQ_W-1:0];
    qq = s[SAMPLE_W-1 -: IQ_W];
    case (q)
        2'd0: return {qq, i};
        2'd1: return {i, neg_sat_ref(qq)};
        2'd2: return {neg_sat_ref(qq), neg_sat_ref(i)};
        default: return {neg_sat_ref(i), qq};
    endcase
endfunction

function automatic logic signed [LLR_W-1:0] clip_ref(input logic signed [IQ_W-1:0] x,
                                                     input int shift);
    int v;
    int lim;
    v   = int'(x) >>> shift;
    lim = 2 ** (LLR_W - 1) - 1;
    if (v > lim)
        v = lim;
    if (v < -lim)
        v = -lim;
    return LLR_W'(v);
endfunction

// ----------------------------------------
// bus access, driven on the falling edge
// ----------------------------------------
task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr,
                         input logic [BUS_DATA_W-1:0] data);
    @(negedge clk);
    bus_req   = 1'b1;
    bus_we    = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    @(negedge clk);
    bus_req = 1'b0;
    bus_we  = 1'b0;
endtask

task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr,
                        output logic [BUS_DATA_W-1:0] data,
                        output logic err);
    @(negedge clk);
    bus_req  = 1'b1;
    bus_we   = 1'b0;
    bus_addr = addr;
    @(negedge clk);
    bus_req = 1'b0;
    data    = bus_rdata;
    err     = bus_err;
endtask

`endif

// File: testbench/tb_rx_top.sv
`timescale 1ns/1ps

module tb_rx_top
    import rx_pkg::*;
();

    localparam int FIFO_DEPTH = 16;
    localparam int LLR_SHIFT  = 8;
    localparam int N_OFF      = 4;
    localparam int N_BASIC    = 12;
    localparam int N_CFO      = 16;
    localparam int N_MIXED    = 6;
    localparam int N_OVF      = 10;
    localparam int BUS_OPS    = 80;
    // two cycles per sample and per bus access, plus idle gaps
    localparam int TIMEOUT_CYCLES = 2 * (N_OFF + N_BASIC + 2 + N_CFO + N_MIXED + N_OVF)
                                    + 2 * BUS_OPS + 200;

    logic                  clk;
    logic                  reset_n;
    logic [SAMPLE_W-1:0]   sample;
    sym_kind_t             sample_kind;
    logic                  sample_valid;
    logic [LLR_W-1:0]      llr;
    sym_kind_t             llr_kind;
    logic                  llr_last;
    logic                  llr_valid;
    logic                  bus_req;
    logic                  bus_we;
    logic [BUS_ADDR_W-1:0] bus_addr;
    logic [BUS_DATA_W-1:0] bus_wdata;
    logic [BUS_DATA_W-1:0] bus_rdata;
    logic                  bus_ack;
    logic                  bus_err;

    logic [15:0]           lfsr_state;
    logic                  enable_model;
    logic [PHASE_W-1:0]    freq_model;
    logic [PHASE_W-1:0]    phase_model;
    logic [LLR_W-1:0]      fifo_model[$];
    logic                  ovf_model;

    // expected llr stream indexed by cycle modulo 8
    logic                  exp_valid[8];
    logic [LLR_W-1:0]      exp_llr[8];
    logic [1:0]            exp_kind[8];
    logic                  exp_last[8];
    int                    cyc;
    logic                  req_d;
    logic                  err_d;
    logic                  checking;
    int                    checks;
    int                    errors;
    string                 test_name;

    `include "tb_util.svh"

    rx_top #(.FIFO_DEPTH(FIFO_DEPTH), .LLR_SHIFT(LLR_SHIFT)) uut (
        .clk_i          (clk),
        .reset_ni       (reset_n),
        .sample_i       (sample),
        .sample_kind_i  (sample_kind),
        .sample_valid_i (sample_valid),
        .llr_o          (llr),
        .llr_kind_o     (llr_kind),
        .llr_last_o     (llr_last),
        .llr_valid_o    (llr_valid),
        .bus_req_i      (bus_req),
        .bus_we_i       (bus_we),
        .bus_addr_i     (bus_addr),
        .bus_wdata_i    (bus_wdata),
        .bus_rdata_o    (bus_rdata),
        .bus_ack_o      (bus_ack),
        .bus_err_o      (bus_err)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            r[b]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic logic [BUS_ADDR_W-1:0] make_addr(input region_t r,
                                                         input logic [OFFSET_W-1:0] off);
        return {r, off};
    endfunction

    function automatic void push_model(input logic [LLR_W-1:0] v);
        if (fifo_model.size() < FIFO_DEPTH)
            fifo_model.push_back(v);
        else
            ovf_model = 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic read_expect(input string name, input logic [BUS_ADDR_W-1:0] addr,
                               input logic [BUS_DATA_W-1:0] expected, input logic exp_err);
        logic [BUS_DATA_W-1:0] data;
        logic                  err;
        bus_read(addr, data, err);
        check_value({name, " data"}, expected, data);
        check_value({name, " err"}, 32'(exp_err), 32'(err));
    endtask

    task automatic set_enable(input logic v);
        bus_write(make_addr(REGION_CTRL, CTRL_ENABLE), {31'd0, v});
        enable_model = v;
    endtask

    task automatic correct_cfo(input logic [BUS_DATA_W-1:0] delta);
        bus_write(make_addr(REGION_CTRL, CTRL_CFO), delta);
        freq_model = freq_model - delta[PHASE_W-1:0];
    endtask

    // one sample followed by a gap cycle
    task automatic send_sample(input logic [SAMPLE_W-1:0] s, input sym_kind_t kind);
        logic [1:0]          q;
        logic [SAMPLE_W-1:0] rot;
        logic [LLR_W-1:0]    li;
        logic [LLR_W-1:0]    lq;
        int                  si;
        int                  sq;
        @(negedge clk);
        sample       = s;
        sample_kind  = kind;
        sample_valid = 1'b1;
        if (enable_model) begin
            q           = phase_model[PHASE_W-1 -: 2];
            phase_model = phase_model + freq_model;
            rot         = rotate_ref(s, q);
            li          = clip_ref(rot[IQ_W-1:0], LLR_SHIFT);
            lq          = clip_ref(rot[SAMPLE_W-1 -: IQ_W], LLR_SHIFT);
            si          = (cyc + 2) % 8;
            sq          = (cyc + 3) % 8;
            exp_valid[si] = 1'b1;
            exp_llr[si]   = li;
            exp_kind[si]  = kind;
            exp_last[si]  = 1'b0;
            exp_valid[sq] = 1'b1;
            exp_llr[sq]   = lq;
            exp_kind[sq]  = kind;
            exp_last[sq]  = 1'b1;
            if (kind == KIND_PBCH) begin
                push_model(li);
                push_model(lq);
            end
        end
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    task automatic drain_fifo();
        logic [LLR_W-1:0] v;
        int               n;
        idle(4);
        read_expect({test_name, " fifo level"}, make_addr(REGION_FIFO, FIFO_LEVEL),
                    {ovf_model, 31'(fifo_model.size())}, 1'b0);
        n = fifo_model.size();
        for (int k = 0; k < n; k++) begin
            v = fifo_model.pop_front();
            read_expect({test_name, " fifo data"}, make_addr(REGION_FIFO, FIFO_DATA),
                        {{(BUS_DATA_W-LLR_W){v[LLR_W-1]}}, v}, 1'b0);
        end
        read_expect({test_name, " fifo empty"}, make_addr(REGION_FIFO, FIFO_DATA), '0, 1'b0);
    endtask

    always @(posedge clk) begin
        cyc   <= cyc + 1;
        req_d <= bus_req;
        err_d <= bus_req && !(region_t'(bus_addr[BUS_ADDR_W-1 -: 2])
                              inside {REGION_FIFO, REGION_CTRL});
    end

    // ----------------------------------------
    // per-cycle output monitor
    // ----------------------------------------
    always @(negedge clk) begin : output_monitor
        int slot;
        slot = cyc % 8;
        if (checking) begin
            check_value({test_name, " ack"}, 32'(req_d), 32'(bus_ack));
            check_value({test_name, " bus err"}, 32'(err_d), 32'(bus_err));
            check_value({test_name, " llr_valid"}, 32'(exp_valid[slot]), 32'(llr_valid));
            check_value({test_name, " llr_last"}, 32'(exp_last[slot]), 32'(llr_last));
            if (exp_valid[slot]) begin
                check_value({test_name, " llr"}, 32'(exp_llr[slot]), 32'(llr));
                check_value({test_name, " llr_kind"}, 32'(exp_kind[slot]), 32'(llr_kind));
            end
        end
        exp_valid[slot] = 1'b0;
        exp_last[slot]  = 1'b0;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] r;
        sym_kind_t   kind;
        clk          = 1'b0;
        reset_n      = 1'b0;
        sample       = '0;
        sample_kind  = KIND_OTHER;
        sample_valid = 1'b0;
        bus_req      = 1'b0;
        bus_we       = 1'b0;
        bus_addr     = '0;
        bus_wdata    = '0;
        lfsr_state   = 16'd14;
        enable_model = 1'b0;
        freq_model   = '0;
        phase_model  = '0;
        ovf_model    = 1'b0;
        cyc          = 0;
        req_d        = 1'b0;
        err_d        = 1'b0;
        checking     = 1'b0;
        checks       = 0;
        errors       = 0;
        test_name    = "reset";
        for (int k = 0; k < 8; k++) begin
            exp_valid[k] = 1'b0;
            exp_last[k]  = 1'b0;
            exp_llr[k]   = '0;
            exp_kind[k]  = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n  = 1'b1;
        checking = 1'b1;

        check_value("reset llr_valid", 32'd0, 32'(llr_valid));
        check_value("reset ack", 32'd0, 32'(bus_ack));
        read_expect("reset level", make_addr(REGION_FIFO, FIFO_LEVEL), '0, 1'b0);
        read_expect("reset enable", make_addr(REGION_CTRL, CTRL_ENABLE), '0, 1'b0);

        // ----------------------------------------
        // enable gating and plain demapping
        // ----------------------------------------
        test_name = "disabled";
        for (int k = 0; k < N_OFF; k++)
            send_sample(random_bits(32), KIND_PBCH);
        idle(4);
        test_name = "enabled";
        set_enable(1'b1);
        read_expect("enable readback", make_addr(REGION_CTRL, CTRL_ENABLE), 32'd1, 1'b0);
        // clipping corners at quadrant 0
        send_sample(32'h8000_8000, KIND_PBCH);
        send_sample(32'h7FFF_80FF, KIND_OTHER);
        for (int k = 0; k < N_BASIC; k++)
            send_sample(random_bits(32), sym_kind_t'(k % 4));
        drain_fifo();

        // ----------------------------------------
        // relative cfo corrections
        // ----------------------------------------
        test_name = "cfo";
        correct_cfo(32'h0001_2345);
        read_expect("cfo negative readback", make_addr(REGION_CTRL, CTRL_CFO),
                    {{(BUS_DATA_W-PHASE_W){freq_model[PHASE_W-1]}}, freq_model}, 1'b0);
        correct_cfo(32'h0000_4000);
        correct_cfo(32'hFFFD_0000);
        correct_cfo(32'h0000_0F00);
        read_expect("cfo readback", make_addr(REGION_CTRL, CTRL_CFO),
                    {{(BUS_DATA_W-PHASE_W){freq_model[PHASE_W-1]}}, freq_model}, 1'b0);
        idle(2);
        // most-negative corner across all quadrants
        for (int k = 0; k < N_CFO; k++) begin
            if (k % 2)
                send_sample(32'h8000_8000, KIND_SSS);
            else
                send_sample(random_bits(32), KIND_SSS);
        end
        idle(4);

        test_name = "mixed";
        for (int k = 0; k < N_MIXED; k++) begin
            r    = random_bits(2);
            kind = sym_kind_t'(r[1:0]);
            send_sample(random_bits(32), kind);
        end
        drain_fifo();

        // ----------------------------------------
        // overflow flag and its clear
        // ----------------------------------------
        test_name = "overflow";
        for (int k = 0; k < N_OVF; k++)
            send_sample(random_bits(32), KIND_PBCH);
        idle(4);
        read_expect("overflow set", make_addr(REGION_FIFO, FIFO_LEVEL),
                    {1'b1, 31'(FIFO_DEPTH)}, 1'b0);
        bus_write(make_addr(REGION_FIFO, FIFO_LEVEL), '0);
        ovf_model = 1'b0;
        read_expect("overflow clear", make_addr(REGION_FIFO, FIFO_LEVEL),
                    {1'b0, 31'(FIFO_DEPTH)}, 1'b0);
        drain_fifo();

        test_name = "unmapped";
        read_expect("unmapped read", 8'h85, '0, 1'b1);
        bus_write(8'hC0, 32'hFFFF_FFFF);
        read_expect("unmapped high", 8'hFF, '0, 1'b1);
        idle(2);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hdl/rx_pkg.sv
hdl/cfo_derotator.sv
hdl/llr_demapper.sv
hdl/pbch_llr_fifo.sv
hdl/ctrl_regs.sv
hdl/reg_bus_decoder.sv
hdl/rx_top.sv
testbench/tb_rx_top.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_top \
    -f verilog.f -o tb_rx_top_sim \
    && ./obj_dir/tb_rx_top_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
